/* hw/app_bank.sv */
/*
 * One on-chip storage bank standing in for a slice of DDR.
 * Writes are stored on the strobe. Reads track the open row:
 * a hit returns after DDR_LAT_HIT cycles, a miss after DDR_LAT_MISS.
 * Local index bits above the bank depth alias.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ddr_defs.svh"

module app_bank #(
    parameter int BANK_ID = 0       // position in the bank array
) (
    input  logic              ui_clk,
    input  logic              rst,
    input  logic              bank_en,
    input  ddr_pkg::app_req_t bank_req,
    output logic              bank_rd_valid,
    output ddr_pkg::rd_beat_t bank_rd
);
    import ddr_pkg::*;

    localparam int   DEPTH   = 1 << `DDR_BANK_AW;
    localparam int   ROW_W   = `DDR_BANK_AW - `DDR_ROW_LSB;
    localparam int   CNT_W   = $clog2(`DDR_LAT_MISS) + 1;
    localparam logic HI_BEAT = BANK_ID[0];   // select bit 0 is the beat position

    beat_t                   mem [DEPTH];
    beat_t                   rd_data;
    logic [`DDR_BANK_AW-1:0] idx;
    logic [ROW_W-1:0]        row;
    logic [ROW_W-1:0]        open_row;       // last row read
    logic                    row_valid;
    logic                    row_hit;
    logic                    rd_req;
    logic                    wr_req;
    logic [CNT_W-1:0]        cnt;            // cycles to read valid

    assign idx     = bank_req.addr[`DDR_BANK_AW-1:0];  // upper bits alias
    assign row     = idx[`DDR_BANK_AW-1:`DDR_ROW_LSB];
    assign rd_req  = bank_en && !bank_req.write;
    assign wr_req  = bank_en && bank_req.write;
    assign row_hit = row_valid && (row == open_row);

    // --------------------
    // storage and read capture
    always_ff @(posedge ui_clk) begin
        if (wr_req) mem[idx] <= bank_req.wdata;
        if (rd_req) rd_data <= mem[idx];
    end

    // row tracking and latency countdown
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            cnt           <= '0;
            bank_rd_valid <= 1'b0;
            row_valid     <= 1'b0;
            open_row      <= '0;
        end else begin
            bank_rd_valid <= (cnt == CNT_W'(1));   // one cycle strobe
            if (rd_req) begin
                cnt       <= row_hit ? CNT_W'(`DDR_LAT_HIT - 1) : CNT_W'(`DDR_LAT_MISS - 1);
                open_row  <= row;
                row_valid <= 1'b1;
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign bank_rd.hi   = HI_BEAT;
    assign bank_rd.data = rd_data;

endmodule

`default_nettype wire

/* hw/app_router.sv */
/*
 * Bank decoder for app side beat requests. Bank select comes from
 * byte address bits [5:4], so a block's lo and hi beats land in
 * adjacent banks. The request goes to all banks with the select bits
 * removed; only the selected bank sees the strobe.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ddr_defs.svh"

module app_router (
    input  logic                      app_en,
    input  ddr_pkg::app_req_t         app_req,
    output logic [`DDR_NUM_BANKS-1:0] bank_en,
    output ddr_pkg::app_req_t         bank_req
);
    import ddr_pkg::*;

    localparam int SEL_LSB   = 4;                          // bytes per beat below
    localparam int LOCAL_LSB = SEL_LSB + `DDR_BANK_SEL_W;  // first local index bit
    localparam int ADDR_W    = $bits(app_addr_t);

    bank_sel_t sel;

    assign sel = app_req.addr[SEL_LSB +: `DDR_BANK_SEL_W];

    // one hot strobe
    always_comb begin
        for (int i = 0; i < `DDR_NUM_BANKS; i++) begin
            bank_en[i] = app_en && (sel == bank_sel_t'(i));
        end
    end

    // --------------------
    // shared request, local index moved down to bit 0
    assign bank_req.write = app_req.write;
    assign bank_req.wdata = app_req.wdata;
    assign bank_req.addr  = {{LOCAL_LSB{1'b0}}, app_req.addr[ADDR_W-1:LOCAL_LSB]};

endmodule

`default_nettype wire

/* hw/ddr_ctrl.sv */
/*
 * CPU side block request adapter. A level request (ram_en, ram_write,
 * word address) is split into two 128-bit beat commands, lo then hi.
 * Read beats come back tagged and are merged into block_out.
 * ram_rdy rises once the held request matches the last completed one.
 */
`timescale 1ns/100ps
`default_nettype none

module ddr_ctrl (
    input  logic               ui_clk,
    input  logic               rst,          // sync, active low
    input  logic               ram_en,       // level, held until ram_rdy
    input  logic               ram_write,
    input  ddr_pkg::ram_addr_t ram_addr,     // 4 byte aligned
    input  ddr_pkg::block_t    data_to_ram,
    output logic               ram_rdy,
    output ddr_pkg::block_t    block_out,
    output logic               app_en,
    output ddr_pkg::app_req_t  app_req,
    input  logic               rd_valid,
    input  ddr_pkg::rd_beat_t  rd
);
    import ddr_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LO,      // lo beat on the app side
        ST_HI,      // hi beat on the app side
        ST_WAIT     // read only, collecting beats
    } ctrl_state_t;

    ctrl_state_t state;
    ram_addr_t   last_addr;    // last completed request
    ram_op_t     last_op;
    ram_op_t     cur_op;
    logic        is_new;
    logic        hi_sel;
    logic        beat_seen;    // first read beat already back

    // --------------------
    // request decode
    assign cur_op = ram_write ? OP_WRITE : OP_READ;
    // block address only, word bits [2:0] ignored
    assign is_new = ram_en &&
                    ((ram_addr[29:3] != last_addr[29:3]) || (cur_op != last_op));
    assign ram_rdy = !is_new && (state == ST_IDLE);

    // --------------------
    // beat commands
    assign hi_sel = (state == ST_HI);
    assign app_en = (state == ST_LO) || (state == ST_HI);
    assign app_req.write = ram_write;
    assign app_req.addr  = {ram_addr[24:3], hi_sel, 4'b0000};  // top 5 bits dropped
    assign app_req.wdata = hi_sel ? data_to_ram[255:128] : data_to_ram[127:0];

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state     <= ST_IDLE;
            last_addr <= '1;
            last_op   <= OP_NOP;      // any enabled request counts as new
            beat_seen <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (is_new) state <= ST_LO;
                end
                ST_LO: state <= ST_HI;
                ST_HI: begin
                    if (ram_write) begin
                        // write done once the hi beat is out
                        last_addr <= ram_addr;
                        last_op   <= cur_op;
                        state     <= ST_IDLE;
                    end else begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rd_valid) begin
                        if (beat_seen) begin
                            // second beat in, block complete
                            last_addr <= ram_addr;
                            last_op   <= cur_op;
                            beat_seen <= 1'b0;
                            state     <= ST_IDLE;
                        end else begin
                            beat_seen <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------
    // read block assembly, halves placed by tag
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            block_out <= '0;
        end else if (rd_valid) begin
            if (rd.hi) block_out[255:128] <= rd.data;
            else       block_out[127:0]   <= rd.data;
        end
    end

endmodule

`default_nettype wire

/* hw/ddr_pkg.sv */
/*
 * Shared types for the DDR block port: address and data widths,
 * the application-side request and read beat structs, and the
 * operation encoding used to spot new CPU requests.
 */
`default_nettype none

`include "ddr_defs.svh"

package ddr_pkg;

    typedef logic [29:0]  ram_addr_t;   // cpu word address in 4 byte units
    typedef logic [26:0]  app_addr_t;   // app side byte address
    typedef logic [127:0] beat_t;       // one app data beat
    typedef logic [255:0] block_t;      // one cpu block of two beats
    typedef logic [`DDR_BANK_SEL_W-1:0] bank_sel_t;  // app addr [5:4]

    // last completed operation
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01,
        OP_NOP   = 2'b11
    } ram_op_t;

    typedef struct packed {
        logic      write;   // high for a write
        app_addr_t addr;
        beat_t     wdata;
    } app_req_t;

    typedef struct packed {
        logic  hi;          // beat position within the block
        beat_t data;
    } rd_beat_t;

endpackage

`default_nettype wire

/* hw/ddr_sub_top.sv */
/*
 * DDR block port subsystem. CPU block requests enter ddr_ctrl, beats are
 * routed to the storage banks, and read beats are merged back.
 * Port list matches the CPU side of ddr_ctrl.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ddr_defs.svh"

module ddr_sub_top (
    input  logic               ui_clk,
    input  logic               rst,
    input  logic               ram_en,
    input  logic               ram_write,
    input  ddr_pkg::ram_addr_t ram_addr,
    input  ddr_pkg::block_t    data_to_ram,
    output logic               ram_rdy,
    output ddr_pkg::block_t    block_out
);
    import ddr_pkg::*;

    logic                      app_en;
    app_req_t                  app_req;
    logic [`DDR_NUM_BANKS-1:0] bank_en;
    app_req_t                  bank_req;       // shared by all banks
    logic [`DDR_NUM_BANKS-1:0] bank_rd_valid;
    rd_beat_t                  bank_rd [`DDR_NUM_BANKS];
    logic                      rd_valid;
    rd_beat_t                  rd;

    ddr_ctrl u_ctrl (
        .ui_clk     (ui_clk),
        .rst        (rst),
        .ram_en     (ram_en),
        .ram_write  (ram_write),
        .ram_addr   (ram_addr),
        .data_to_ram(data_to_ram),
        .ram_rdy    (ram_rdy),
        .block_out  (block_out),
        .app_en     (app_en),
        .app_req    (app_req),
        .rd_valid   (rd_valid),
        .rd         (rd)
    );

    app_router u_router (
        .app_en  (app_en),
        .app_req (app_req),
        .bank_en (bank_en),
        .bank_req(bank_req)
    );

    // --------------------
    // storage banks
    for (genvar i = 0; i < `DDR_NUM_BANKS; i++) begin : g_bank
        app_bank #(.BANK_ID(i)) u_bank (
            .ui_clk       (ui_clk),
            .rst          (rst),
            .bank_en      (bank_en[i]),
            .bank_req     (bank_req),
            .bank_rd_valid(bank_rd_valid[i]),
            .bank_rd      (bank_rd[i])
        );
    end

    rd_merge u_merge (
        .ui_clk       (ui_clk),
        .rst          (rst),
        .bank_rd_valid(bank_rd_valid),
        .bank_rd      (bank_rd),
        .rd_valid     (rd_valid),
        .rd           (rd)
    );

endmodule

`default_nettype wire

/* hw/rd_merge.sv */
/*
 * Read beat merge. Collects strobed beats from all banks into one
 * registered stream, lowest bank first. Beats that lose a collision
 * wait in a per-bank holding register and go out in later cycles.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ddr_defs.svh"

module rd_merge (
    input  logic                      ui_clk,
    input  logic                      rst,
    input  logic [`DDR_NUM_BANKS-1:0] bank_rd_valid,
    input  ddr_pkg::rd_beat_t         bank_rd [`DDR_NUM_BANKS],
    output logic                      rd_valid,
    output ddr_pkg::rd_beat_t         rd
);
    import ddr_pkg::*;

    logic [`DDR_NUM_BANKS-1:0] pend_v;                    // holding entry in use
    rd_beat_t                  pend      [`DDR_NUM_BANKS];
    logic [`DDR_NUM_BANKS-1:0] cand;                      // held or arriving
    rd_beat_t                  cand_beat [`DDR_NUM_BANKS];
    bank_sel_t                 pick;
    logic                      pick_v;

    // --------------------
    // a bank never has a held and a new beat together
    always_comb begin
        pick   = '0;
        pick_v = 1'b0;
        for (int i = `DDR_NUM_BANKS - 1; i >= 0; i--) begin
            cand[i]      = pend_v[i] || bank_rd_valid[i];
            cand_beat[i] = pend_v[i] ? pend[i] : bank_rd[i];
            if (cand[i]) begin
                pick   = bank_sel_t'(i);   // lowest bank wins
                pick_v = 1'b1;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            rd_valid <= 1'b0;
            pend_v   <= '0;
        end else begin
            rd_valid <= pick_v;
            for (int i = 0; i < `DDR_NUM_BANKS; i++) begin
                pend_v[i] <= cand[i] && !(pick_v && (pick == bank_sel_t'(i)));
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        rd <= cand_beat[pick];
        for (int i = 0; i < `DDR_NUM_BANKS; i++) begin
            if (bank_rd_valid[i]) pend[i] <= bank_rd[i];
        end
    end

endmodule

`default_nettype wire

/* include/ddr_defs.svh */
/*
 * Geometry and timing constants for the DDR block port model.
 * Covers the bank count, the per-bank depth and the open-row read latencies.
 * Include this header in any file that sizes logic from these values.
 */
`ifndef DDR_DEFS_SVH
`define DDR_DEFS_SVH

// --------------------
// bank array
`define DDR_NUM_BANKS   4   // power of two only
`define DDR_BANK_SEL_W  2   // log2 of bank count

// beats per bank as an address width, 128 beats
// 4 banks x 128 beats / 2 beats per block = 256 blocks, aliasing above ram_addr[10]
`define DDR_BANK_AW     7
`define DDR_ROW_LSB     3   // lowest row bit of the local index, 8 beats per row

// --------------------
// read latency, request strobe to bank read valid
`define DDR_LAT_HIT     2   // open row
`define DDR_LAT_MISS    4   // row change or first read

`endif

/* run.sh */
#!/bin/sh
# build and run tb_ddr_sub with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_ddr_sub -f vlog.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_ddr_sub)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verif/ddr_sub_sva.sv */
/*
 * Assertions bound onto the DDR block port top level.
 * Covers app side commands during reset, read returns while a write
 * is being issued, and block_out holding while the CPU port is idle.
 */
`timescale 1ns/100ps
`default_nettype none

module ddr_sub_sva (
    input logic            ui_clk,
    input logic            rst,
    input logic            ram_en,
    input logic            app_en,
    input logic            app_write,   // write bit of the app request
    input logic            rd_valid,
    input ddr_pkg::block_t block_out
);

    // --------------------
    // reset has been seen at least one edge
    a_no_app_in_reset: assert property (@(posedge ui_clk)
        (!rst && $past(!rst)) |-> !app_en
    ) else $error("app_en high while rst low");

    // no read beats in flight behind a write
    a_no_rd_in_write: assert property (@(posedge ui_clk) disable iff (!rst)
        (app_en && app_write) |-> !$rose(rd_valid)
    ) else $error("rd_valid rose during write issue");

    a_block_hold: assert property (@(posedge ui_clk) disable iff (!rst)
        (!ram_en && $past(!ram_en)) |-> $stable(block_out)
    ) else $error("block_out changed with ram_en low");

endmodule

bind ddr_sub_top ddr_sub_sva u_sva (
    .ui_clk   (ui_clk),
    .rst      (rst),
    .ram_en   (ram_en),
    .app_en   (app_en),
    .app_write(app_req.write),
    .rd_valid (rd_valid),
    .block_out(block_out)
);

`default_nettype wire

/* verif/tb_ddr_sub.sv */
/*
 * Directed testbench for the DDR block port subsystem.
 * Writes LFSR blocks through the CPU port and keeps a reference memory
 * indexed by ram_addr[10:3], since higher bits alias. It reads back through
 * the bank model and checks ram_rdy timing against hit and miss latencies.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_ddr_sub;
    import ddr_pkg::*;

    localparam int RDY_TIMEOUT = 40;  // cycles, longest read is 8
    localparam int LAT_WR      = 3;   // lo issue, hi issue, done
    localparam int LAT_RD_HIT  = 6;   // 2 issue + 2 bank + merge + capture
    localparam int LAT_RD_MISS = 8;   // 2 issue + 4 bank + merge + capture
    localparam int NUM_RAND    = 12;

    logic      ui_clk;
    logic      rst;
    logic      ram_en;
    logic      ram_write;
    ram_addr_t ram_addr;
    block_t    data_to_ram;
    logic      ram_rdy;
    block_t    block_out;

    block_t      ref_mem [256];       // one entry per aliased block
    ram_addr_t   addr_q  [NUM_RAND];
    logic [15:0] lfsr;
    int          checks;
    int          errors;
    int          timeouts;
    int          tests;
    int          fail_mark;           // failures counted at last test end

    ddr_sub_top u_ddr_sub_top (
        .ui_clk     (ui_clk),
        .rst        (rst),
        .ram_en     (ram_en),
        .ram_write  (ram_write),
        .ram_addr   (ram_addr),
        .data_to_ram(data_to_ram),
        .ram_rdy    (ram_rdy),
        .block_out  (block_out)
    );

    initial begin
        ui_clk = 1'b0;
        forever #5 ui_clk = ~ui_clk;   // 10 ns
    end

    // --------------------
    // stimulus source, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic block_t rand_bits(input int n);
        block_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);     // one step per bit
            v    = {v[254:0], lfsr[0]};
        end
        return v;
    endfunction

    // --------------------
    // compare helpers
    task automatic check_block(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    // counts rising edges until ram_rdy, sampled on the falling edge
    task automatic wait_ready(input string what, output int cycles);
        cycles = 0;
        do begin
            @(posedge ui_clk);
            @(negedge ui_clk);
            cycles++;
        end while (!ram_rdy && cycles < RDY_TIMEOUT);
        if (!ram_rdy) begin
            timeouts++;
            $display("timeout: ram_rdy stayed low for %0d cycles during %s", cycles, what);
        end
    endtask

    // --------------------
    // CPU port requests, called on a falling edge
    task automatic do_write(input ram_addr_t addr, input block_t data);
        int c;
        ram_en      = 1'b1;
        ram_write   = 1'b1;
        ram_addr    = addr;
        data_to_ram = data;
        wait_ready("write", c);
        check_latency("ram_rdy write latency", c, LAT_WR);  // every write here is new
        ref_mem[addr[10:3]] = data;
    endtask

    task automatic do_read(input ram_addr_t addr, output int cycles);
        ram_en    = 1'b1;
        ram_write = 1'b0;
        ram_addr  = addr;
        wait_ready("read", cycles);
        check_block("block_out", block_out, ref_mem[addr[10:3]]);
    endtask

    task automatic do_hold(input int n, input block_t exp);
        int c;
        wait_ready("hold", c);
        repeat (n) begin
            @(posedge ui_clk);
            @(negedge ui_clk);
            check_flag("ram_rdy", ram_rdy, 1'b1);
            check_block("block_out", block_out, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors + timeouts == fail_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d failures", tests, name, errors + timeouts - fail_mark);
        end
        fail_mark = errors + timeouts;
    endtask

    // --------------------
    // directed tests
    task automatic check_after_reset();
        @(posedge ui_clk);
        @(negedge ui_clk);
        check_flag("ram_rdy", ram_rdy, 1'b1);     // ram_en low
        check_block("block_out", block_out, '0);
    endtask

    task automatic write_then_read();
        int c;
        do_write(30'h0000_0048, rand_bits(256));
        do_read(30'h0000_0048, c);
    endtask

    task automatic hold_request();
        do_hold(20, ref_mem[8'h09]);   // read of 0x48 still presented
        ram_en = 1'b0;
        do_hold(5, ref_mem[8'h09]);
    endtask

    task automatic scatter_blocks();
        int c;
        for (int i = 0; i < NUM_RAND; i++) begin
            addr_q[i] = ram_addr_t'(rand_bits(30));  // high bits alias
            do_write(addr_q[i], rand_bits(256));
        end
        // stride 5 is coprime to 12, visits all in a new order
        for (int k = 0; k < NUM_RAND; k++) begin
            do_read(addr_q[(k * 5 + 3) % NUM_RAND], c);
        end
    endtask

    task automatic row_hit_miss();
        int c;
        do_write(30'h0000_0100, rand_bits(256));  // row 2, banks 0/1
        do_write(30'h0000_0110, rand_bits(256));  // row 2, next entry
        do_write(30'h0000_0400, rand_bits(256));  // row 8
        do_read(30'h0000_0100, c);                // opens row 2
        do_read(30'h0000_0110, c);
        check_latency("ram_rdy read hit latency", c, LAT_RD_HIT);
        do_read(30'h0000_0400, c);
        check_latency("ram_rdy read miss latency", c, LAT_RD_MISS);
        do_read(30'h0000_0110, c);                // row 2 closed again
        check_latency("ram_rdy read miss latency", c, LAT_RD_MISS);
    endtask

    task automatic alias_reads();
        int c;
        do_read(30'h2AAA_A905, c);                // index 0x20, word bits ignored
        do_read(addr_q[0] ^ 30'h2000_8000, c);    // bits 29 and 15 flipped
    endtask

    initial begin
        rst         = 1'b0;
        ram_en      = 1'b0;
        ram_write   = 1'b0;
        ram_addr    = '0;
        data_to_ram = '0;
        lfsr        = 16'd6878;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        tests       = 0;
        fail_mark   = 0;
        repeat (8) @(posedge ui_clk);
        @(negedge ui_clk);
        rst = 1'b1;

        check_after_reset();
        report_test("reset state");
        write_then_read();
        report_test("write then read");
        hold_request();
        report_test("held request");
        scatter_blocks();
        report_test("scattered blocks");
        row_hit_miss();
        report_test("row hit and miss");
        alias_reads();
        report_test("aliased reads");

        $display("tests %0d, checks %0d, errors %0d, timeouts %0d",
                 tests, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hw/ddr_pkg.sv
hw/ddr_ctrl.sv
hw/app_router.sv
hw/app_bank.sv
hw/rd_merge.sv
hw/ddr_sub_top.sv
verif/ddr_sub_sva.sv
verif/tb_ddr_sub.sv
